/* Bender.yml */
package:
  name: stream_merge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - stream_merge_pkg.sv
      - cdc_fifo.sv
      - rr_merge_arbiter.sv
      - stream_merge.sv
  - target: test
    include_dirs:
      - .
    files:
      - stream_merge_checker.sv
      - stream_merge_tb.sv

/* cdc_fifo.sv */
`include "stream_merge_macros.svh"

module cdc_fifo #(
    parameter type payload_t = logic [`STREAM_MERGE_DATA_W-1:0], // Entry type
    parameter int  AW        = `STREAM_MERGE_FIFO_AW             // Depth is 2**AW
) (
    // Write side, w_clk domain
    input  logic     w_clk,
    input  logic     w_valid,
    input  payload_t w_data,
    output logic     w_ready,      // Not full
    // Read side, r_clk domain
    input  logic     r_clk,
    input  logic     r_readyAsync, // Async reset, active low, clears both domains
    output logic     r_valid,      // Not empty
    output payload_t r_data,       // Head entry, show-ahead
    input  logic     r_ready
);
    localparam int DEPTH = 1 << AW;

    // Storage, written in w_clk and read combinationally in r_clk
    payload_t mem [DEPTH];

    // Write domain state
    logic [AW:0] w_bin;        // Binary write pointer, one extra wrap bit
    logic [AW:0] w_bin_next;
    logic [AW:0] w_gray;       // Gray copy that crosses to r_clk
    logic [AW:0] w_gray_next;
    logic [AW:0] r_gray_wq1;   // Read pointer, first sync stage
    logic [AW:0] r_gray_wq2;   // Read pointer, safe to use in w_clk
    logic        w_full;
    logic        w_push;

    // Read domain state
    logic [AW:0] r_bin;
    logic [AW:0] r_bin_next;
    logic [AW:0] r_gray;
    logic [AW:0] r_gray_next;
    logic [AW:0] w_gray_rq1;   // Write pointer, first sync stage
    logic [AW:0] w_gray_rq2;   // Write pointer, safe to use in r_clk
    logic        r_pop;

    // Only one bit changes per increment
    function automatic logic [AW:0] bin2gray(input logic [AW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // ========================================
    // Write domain
    // ========================================
    assign w_push      = w_valid && w_ready;       // Handshake on w_clk
    assign w_bin_next  = w_bin + 1'b1;
    assign w_gray_next = bin2gray(w_bin_next);

    always_ff @(posedge w_clk or negedge r_readyAsync) begin
        if (!r_readyAsync) begin
            w_bin  <= '0;
            w_gray <= '0;
        end else if (w_push) begin
            w_bin  <= w_bin_next;
            w_gray <= w_gray_next;                 // Registered, glitch free crossing
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_push) begin
            mem[w_bin[AW-1:0]] <= w_data;          // Wrap bit not used for addressing
        end
    end

    // Two-flop synchronizer for the read pointer
    always_ff @(posedge w_clk or negedge r_readyAsync) begin
        if (!r_readyAsync) begin
            r_gray_wq1 <= '0;
            r_gray_wq2 <= '0;
        end else begin
            r_gray_wq1 <= r_gray;
            r_gray_wq2 <= r_gray_wq1;
        end
    end

    // Full when the write pointer is one lap ahead
    // In gray code that means the top two bits differ and the rest match
    assign w_full  = (w_gray == {~r_gray_wq2[AW:AW-1], r_gray_wq2[AW-2:0]});
    assign w_ready = !w_full;

    // ========================================
    // Read domain
    // ========================================
    assign r_pop       = r_valid && r_ready;       // Handshake on r_clk
    assign r_bin_next  = r_bin + 1'b1;
    assign r_gray_next = bin2gray(r_bin_next);

    always_ff @(posedge r_clk or negedge r_readyAsync) begin
        if (!r_readyAsync) begin
            r_bin  <= '0;
            r_gray <= '0;
        end else if (r_pop) begin
            r_bin  <= r_bin_next;
            r_gray <= r_gray_next;
        end
    end

    // Two-flop synchronizer for the write pointer
    always_ff @(posedge r_clk or negedge r_readyAsync) begin
        if (!r_readyAsync) begin
            w_gray_rq1 <= '0;
            w_gray_rq2 <= '0;
        end else begin
            w_gray_rq1 <= w_gray;
            w_gray_rq2 <= w_gray_rq1;
        end
    end

    // Empty is plain pointer equality
    // Combinational so a write shows up right after the second sync stage
    assign r_valid = (r_gray != w_gray_rq2);

    // Show-ahead head entry
    // Stable while r_valid is high and no pop happens
    assign r_data  = mem[r_bin[AW-1:0]];

endmodule

/* rr_merge_arbiter.sv */
module rr_merge_arbiter (
    input  logic                      r_clk,
    input  logic                      r_readyAsync, // Async reset, active low
    // Source 0 FIFO head
    input  logic                      word_valid,
    input  stream_merge_pkg::word_t   word_data,
    output logic                      word_ready,
    // Source 1 FIFO head
    input  logic                      byte_valid,
    input  stream_merge_pkg::byte_t   byte_data,
    output logic                      byte_ready,
    // Merged output bus
    output logic                      out_valid,
    output stream_merge_pkg::src_id_t out_src,
    output stream_merge_pkg::word_t   out_data,
    input  logic                      out_ready
);
    import stream_merge_pkg::*;

    localparam src_id_t SRC_WORD = src_id_t'(0);
    localparam src_id_t SRC_BYTE = src_id_t'(1);
    localparam int      PAD_W    = $bits(word_t) - $bits(byte_t); // Zero bits above a byte

    logic    load_ok;     // Output register free this cycle
    src_id_t grant;       // Source picked this cycle
    src_id_t last_grant;  // Source of the last loaded word
    logic    take;        // A head moves into the output register
    word_t   byte_wide;   // Byte head widened to the output width

    // ========================================
    // Grant selection
    // ========================================

    // Free when empty or drained on this same edge
    assign load_ok = !out_valid || out_ready;

    always_comb begin
        if (word_valid && byte_valid) begin
            // Contested, alternate away from the last winner
            grant = (last_grant == SRC_WORD) ? SRC_BYTE : SRC_WORD;
        end else if (byte_valid) begin
            grant = SRC_BYTE;
        end else begin
            grant = SRC_WORD;                     // Also the idle default
        end
    end

    // Exactly one ready whenever the register can accept
    assign word_ready = load_ok && (grant == SRC_WORD);
    assign byte_ready = load_ok && (grant == SRC_BYTE);

    assign take = (word_ready && word_valid) || (byte_ready && byte_valid);

    assign byte_wide = {{PAD_W{1'b0}}, byte_data};

    // ========================================
    // Output register
    // ========================================
    always_ff @(posedge r_clk or negedge r_readyAsync) begin
        if (!r_readyAsync) begin
            out_valid  <= 1'b0;
            last_grant <= SRC_BYTE;               // First contest goes to source 0
        end else if (take) begin
            out_valid  <= 1'b1;                   // Refill, possibly back to back
            last_grant <= grant;
        end else if (out_ready) begin
            out_valid  <= 1'b0;                   // Drained with nothing to replace it
        end
    end

    // Payload only changes on a load
    // Held steady under back-pressure
    always_ff @(posedge r_clk) begin
        if (take) begin
            out_src  <= grant;
            out_data <= (grant == SRC_BYTE) ? byte_wide : word_data;
        end
    end

endmodule

/* stream_merge.f */
+incdir+.
stream_merge_pkg.sv
cdc_fifo.sv
rr_merge_arbiter.sv
stream_merge.sv
stream_merge_checker.sv
stream_merge_tb.sv

/* stream_merge.sv */
`include "stream_merge_macros.svh"

module stream_merge (
    input  logic                      r_clk,
    input  logic                      r_readyAsync, // Async reset, active low
    input  logic                      w_clk,
    // Source 0, 16-bit words in w_clk
    input  logic                      src0_valid,
    input  stream_merge_pkg::word_t   src0_data,
    output logic                      src0_ready,
    // Source 1, bytes in w_clk
    input  logic                      src1_valid,
    input  stream_merge_pkg::byte_t   src1_data,
    output logic                      src1_ready,
    // Merged output in r_clk
    output logic                      out_valid,
    output stream_merge_pkg::src_id_t out_src,
    output stream_merge_pkg::word_t   out_data,
    input  logic                      out_ready
);
    import stream_merge_pkg::*;

    // FIFO heads towards the arbiter
    logic  word_head_valid;
    word_t word_head_data;
    logic  word_head_ready;
    logic  byte_head_valid;
    byte_t byte_head_data;
    logic  byte_head_ready;

    // ========================================
    // Clock crossing FIFOs
    // ========================================
    cdc_fifo #(
        .payload_t (word_t),
        .AW        (`STREAM_MERGE_FIFO_AW)
    ) fifo_word (
        .w_clk        (w_clk),
        .w_valid      (src0_valid),
        .w_data       (src0_data),
        .w_ready      (src0_ready),
        .r_clk        (r_clk),
        .r_readyAsync (r_readyAsync),
        .r_valid      (word_head_valid),
        .r_data       (word_head_data),
        .r_ready      (word_head_ready)
    );

    cdc_fifo #(
        .payload_t (byte_t),            // Narrow entries for source 1
        .AW        (`STREAM_MERGE_FIFO_AW)
    ) fifo_byte (
        .w_clk        (w_clk),
        .w_valid      (src1_valid),
        .w_data       (src1_data),
        .w_ready      (src1_ready),
        .r_clk        (r_clk),
        .r_readyAsync (r_readyAsync),
        .r_valid      (byte_head_valid),
        .r_data       (byte_head_data),
        .r_ready      (byte_head_ready)
    );

    // ========================================
    // Round-robin merge
    // ========================================
    rr_merge_arbiter arbiter_i (
        .r_clk        (r_clk),
        .r_readyAsync (r_readyAsync),
        .word_valid   (word_head_valid),
        .word_data    (word_head_data),
        .word_ready   (word_head_ready),
        .byte_valid   (byte_head_valid),
        .byte_data    (byte_head_data),
        .byte_ready   (byte_head_ready),
        .out_valid    (out_valid),
        .out_src      (out_src),
        .out_data     (out_data),
        .out_ready    (out_ready)
    );

endmodule

/* stream_merge_checker.sv */
module stream_merge_checker (
    input  logic                      r_clk,
    input  logic                      r_readyAsync,
    input  logic                      out_valid,
    input  logic                      out_ready,
    input  stream_merge_pkg::src_id_t out_src,
    input  stream_merge_pkg::word_t   out_data
);
    timeunit 1ns;
    timeprecision 100ps;
    import stream_merge_pkg::*;

    localparam int DATA_W = $bits(word_t);

    int unsigned fail_count = 0;  // Failed assertions so far

    // Register is cleared by the async reset
    a_idle_in_reset: assert property (@(posedge r_clk) !r_readyAsync |-> !out_valid)
        else begin
            $error("out_valid high while reset is asserted");
            fail_count++;
        end

    // Stalled word must hold until taken
    a_hold_on_stall: assert property (@(posedge r_clk) disable iff (!r_readyAsync)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_src) && $stable(out_data)))
        else begin
            $error("output changed while stalled");
            fail_count++;
        end

    a_byte_zero_ext: assert property (@(posedge r_clk) disable iff (!r_readyAsync)
        (out_valid && out_src == src_id_t'(1)) |-> (out_data[DATA_W-1:8] == '0))
        else begin
            $error("byte word has a nonzero upper byte");  // Source 1 is zero-extended
            fail_count++;
        end

    a_valid_known: assert property (@(posedge r_clk) disable iff (!r_readyAsync)
        !$isunknown(out_valid))
        else begin
            $error("out_valid is unknown after reset");
            fail_count++;
        end

endmodule

bind stream_merge stream_merge_checker checker_i (
    .r_clk(r_clk), .r_readyAsync(r_readyAsync), .out_valid(out_valid),
    .out_ready(out_ready), .out_src(out_src), .out_data(out_data)
);

/* stream_merge_macros.svh */
`ifndef STREAM_MERGE_MACROS_SVH
`define STREAM_MERGE_MACROS_SVH

// ========================================
// Stream merge build constants
// ========================================

// Log2 of the FIFO depth (8 entries)
`define STREAM_MERGE_FIFO_AW 3

// Output data width in bits
// Source 0 words use the full width
`define STREAM_MERGE_DATA_W 16

// Number of merged sources
// Sets the tag width in the package
`define STREAM_MERGE_SRC_N 2

`endif

/* stream_merge_pkg.sv */
`include "stream_merge_macros.svh"

package stream_merge_pkg;

    // ========================================
    // Source tag sizing
    // ========================================
    localparam int SRC_N = `STREAM_MERGE_SRC_N;            // Sources on the output bus
    localparam int SRC_W = (SRC_N > 1) ? $clog2(SRC_N) : 1; // At least one tag bit

    // ========================================
    // Payload types
    // ========================================

    // Source 0 payload, also the output data field
    typedef logic [`STREAM_MERGE_DATA_W-1:0] word_t;

    // Source 1 payload
    // Zero-extended to word_t on the output bus
    typedef logic [7:0] byte_t;

    // Tag that says which source a word came from
    typedef logic [SRC_W-1:0] src_id_t;

endpackage

/* stream_merge_tb.sv */
`include "stream_merge_macros.svh"

module stream_merge_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import stream_merge_pkg::*;

    localparam int          TIMEOUT_CYCLES = 6000;  // Tests need a few hundred r_clk cycles
    localparam int          CAPACITY = (1 << `STREAM_MERGE_FIFO_AW) + 1;  // FIFO plus out reg
    localparam logic [31:0] SEED = 32'h011f_fb76;

    logic    r_clk;
    logic    w_clk;
    logic    r_readyAsync;
    logic    src0_valid;
    word_t   src0_data;
    logic    src0_ready;
    logic    src1_valid;
    byte_t   src1_data;
    logic    src1_ready;
    logic    out_valid;
    src_id_t out_src;
    word_t   out_data;
    logic    out_ready;

    word_t       exp_word[$];   // Expected source 0 stream
    byte_t       exp_byte[$];   // Expected source 1 stream
    src_id_t     src_log[$];    // Tags of transfers, in order
    logic [31:0] rng_w;         // Separate LCG state per thread
    logic [31:0] rng_b;
    logic [31:0] rng_o;
    int          err_count;
    int          tests_run;
    int          tests_failed;
    int          word_rx;
    int          byte_rx;
    int          cycle_count;

    stream_merge stream_merge_i (.*);

    always #50 r_clk = ~r_clk;  // 100 ns
    always #35 w_clk = ~w_clk;  // 70 ns

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED t=%0t %s got %h expected %h", $time, sig, got, exp);
        err_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR t=%0t %s", $time, msg);
        err_count++;
    endtask

    // ========================================
    // Output monitor, pre-edge values
    // ========================================
    always @(posedge r_clk) begin
        if (r_readyAsync && out_valid === 1'b1 && out_ready === 1'b1) begin
            src_log.push_back(out_src);
            if (out_src == src_id_t'(0)) begin
                word_rx++;
                if (exp_word.size() == 0) begin
                    report_error("word arrived that was never sent");
                end else begin
                    if (out_data !== exp_word[0])
                        report_mismatch("out_data", out_data, exp_word[0]);
                    void'(exp_word.pop_front());
                end
            end else begin
                byte_rx++;
                if (exp_byte.size() == 0) begin
                    report_error("byte arrived that was never sent");
                end else begin
                    if (out_data !== {8'h00, exp_byte[0]})      // Zero-extended
                        report_mismatch("out_data", out_data, {8'h00, exp_byte[0]});
                    void'(exp_byte.pop_front());
                end
            end
        end
    end

    // Watchdog
    always @(posedge r_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d r_clk cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ========================================
    // Drivers, entered 5 ns after a w_clk edge
    // ========================================
    task automatic push_word(input word_t d, input int max_cycles, output bit ok);
        int n;
        n = 0;
        ok = 0;
        src0_valid = 1'b1;
        src0_data = d;
        while (!ok && n < max_cycles) begin
            @(posedge w_clk);
            n++;
            if (src0_ready === 1'b1) ok = 1;  // Taken on this edge
        end
        if (ok) exp_word.push_back(d);
        #5;
    endtask

    task automatic push_byte(input byte_t d, input int max_cycles, output bit ok);
        int n;
        n = 0;
        ok = 0;
        src1_valid = 1'b1;
        src1_data = d;
        while (!ok && n < max_cycles) begin
            @(posedge w_clk);
            n++;
            if (src1_ready === 1'b1) ok = 1;
        end
        if (ok) exp_byte.push_back(d);
        #5;
    endtask

    task automatic send_words(input int count);
        bit ok;
        @(posedge w_clk);
        #5;
        for (int i = 0; i < count; i++) begin
            rng_w = lcg_next(rng_w);
            push_word(rng_w[31:16], 200, ok);
            if (!ok) report_error("source 0 word never accepted");
        end
        src0_valid = 1'b0;
    endtask

    task automatic send_bytes(input int count);
        bit ok;
        @(posedge w_clk);
        #5;
        for (int i = 0; i < count; i++) begin
            rng_b = lcg_next(rng_b);
            push_byte(rng_b[23:16], 200, ok);
            if (!ok) report_error("source 1 byte never accepted");
        end
        src1_valid = 1'b0;
    endtask

    task automatic set_out_ready(input logic v);
        @(posedge r_clk);
        #5;
        out_ready = v;
    endtask

    // Waits until every sent item has come out
    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while ((exp_word.size() != 0 || exp_byte.size() != 0) && n < max_cycles) begin
            @(posedge r_clk);
            n++;
        end
        if (exp_word.size() != 0 || exp_byte.size() != 0)
            report_error("output did not drain, items still missing");
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (err_count == err_before) $display("%s: passed", name);
        else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - err_before);
        end
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_reset_state();
        int e0;
        e0 = err_count;
        if (out_valid !== 1'b0) report_mismatch("out_valid", out_valid, 0);
        if (src0_ready !== 1'b1) report_mismatch("src0_ready", src0_ready, 1);
        if (src1_ready !== 1'b1) report_mismatch("src1_ready", src1_ready, 1);
        finish_test("reset_state", e0);
    endtask

    task automatic test_single_source(input bit use_bytes);
        int e0;
        int rx0;
        int got;
        e0 = err_count;
        rx0 = use_bytes ? byte_rx : word_rx;
        set_out_ready(1'b1);
        if (use_bytes) send_bytes(20);
        else send_words(20);
        wait_drain(200);
        got = (use_bytes ? byte_rx : word_rx) - rx0;
        if (got != 20) report_mismatch(use_bytes ? "byte count" : "word count", got, 20);
        finish_test(use_bytes ? "byte_only" : "word_only", e0);
    endtask

    task automatic test_both_sources();
        int  e0;
        bit  done0;
        bit  done1;
        e0 = err_count;
        done0 = 0;
        done1 = 0;
        fork
            begin
                send_words(20);
                done0 = 1;
            end
            begin
                send_bytes(20);
                done1 = 1;
            end
            while (!(done0 && done1)) begin
                @(posedge r_clk);
                #5;
                rng_o = lcg_next(rng_o);
                out_ready = rng_o[16];          // Random back-pressure
            end
        join
        set_out_ready(1'b1);
        wait_drain(300);
        finish_test("both_sources", e0);
    endtask

    task automatic test_fairness();
        int e0;
        e0 = err_count;
        set_out_ready(1'b0);
        fork
            send_words(8);
            send_bytes(8);
        join
        repeat (4) @(posedge r_clk);            // Covers the 2 to 3 edge sync latency
        src_log.delete();
        set_out_ready(1'b1);
        wait_drain(200);
        if (src_log.size() < 16) begin
            report_error("fewer transfers than items sent");
        end else begin
            for (int i = 1; i < 16; i++) begin  // Both sides hold data all the way
                if (src_log[i] == src_log[i-1])
                    report_mismatch("out_src", src_log[i], !src_log[i-1]);
            end
        end
        finish_test("fairness", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        int n;
        int rx0;
        bit ok;
        e0 = err_count;
        rx0 = word_rx;
        n = 0;
        ok = 1;
        set_out_ready(1'b0);
        @(posedge w_clk);
        #5;
        while (ok && n < CAPACITY + 3) begin
            rng_w = lcg_next(rng_w);
            push_word(rng_w[31:16], 16, ok);    // Long enough for the full flag to clear
            if (ok) n++;
        end
        src0_valid = 1'b0;
        if (n != CAPACITY) report_mismatch("accepted words", n, CAPACITY);
        set_out_ready(1'b1);
        wait_drain(200);
        if (word_rx - rx0 != n) report_mismatch("drained words", word_rx - rx0, n);
        finish_test("backpressure", e0);
    endtask

    initial begin
        r_clk = 1'b0;
        w_clk = 1'b0;
        r_readyAsync = 1'b1;
        src0_valid = 1'b0;
        src0_data = '0;
        src1_valid = 1'b0;
        src1_data = '0;
        out_ready = 1'b0;
        rng_w = SEED;
        rng_b = lcg_next(SEED ^ 32'h0000_ffff);
        rng_o = lcg_next(SEED ^ 32'hffff_0000);
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;
        word_rx = 0;
        byte_rx = 0;
        cycle_count = 0;
        #1 r_readyAsync = 1'b0;                 // Clean falling edge for the async reset
        repeat (8) @(posedge r_clk);
        #5 r_readyAsync = 1'b1;
        test_reset_state();
        test_single_source(1'b0);
        test_single_source(1'b1);
        test_both_sources();
        test_fairness();
        test_backpressure();
        if (stream_merge_i.checker_i.fail_count != 0)
            report_error($sformatf("%0d checker assertions failed",
                                   stream_merge_i.checker_i.fail_count));
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d words, %0d bytes",
                 tests_run, tests_failed, err_count, word_rx, byte_rx);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
